/* verilog/ibus_pkg.sv */
package ibus_pkg;

    localparam int XLEN       = 32;
    localparam int ROM_WORDS  = 32;
    localparam int ROM_AW     = $clog2(ROM_WORDS);
    localparam int PT_ENTRIES = 4;

    localparam logic [XLEN-1:0] RESET_PC  = 32'hbfc0_0000;   // kseg1, unmapped
    localparam string           IMEM_FILE = "imem.hex";

    typedef struct packed {
        logic [3:0] tag;                                     // Address bits 29:26
        logic       valid;
    } pt_entry_t;

    // Entry 3 first
    localparam pt_entry_t [PT_ENTRIES-1:0] PAGE_TABLE = '{
        '{tag: 4'hc, valid: 1'b1},
        '{tag: 4'h4, valid: 1'b0},
        '{tag: 4'h1, valid: 1'b1},
        '{tag: 4'h0, valid: 1'b1}
    };

    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic            addr_ok;
        logic            data_ok;
        logic [XLEN-1:0] rdata;
    } ibus_resp_t;

    typedef struct packed {
        logic tlb_invalid;
        logic tlb_refill;
        logic mapped;
    } tu_op_resp_t;

    // Bit 1 claims the address phase, bit 0 the data phase
    typedef enum logic [1:0] {
        NONE      = 2'b00,
        ADDR      = 2'b10,
        ADDR_DATA = 2'b11
    } cop_kind_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        tu_op_resp_t     flags;
    } fetch_out_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
    } cop_cmd_t;

endpackage

/* verilog/fetch_req.sv */
`timescale 1ns/1ps

module fetch_req import ibus_pkg::*; (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_stall,
    input  logic            i_flush,
    input  logic [XLEN-1:0] i_redirect_pc,
    input  ibus_resp_t      i_resp,
    input  tu_op_resp_t     i_tu,
    output ibus_req_t       o_req,
    output logic            o_finish,
    output fetch_out_t      o_fetch
);

    logic [XLEN-1:0] pc_q;
    logic            wait_q;
    tu_op_resp_t     flags_q;
    logic            out_valid_q;
    logic [XLEN-1:0] out_pc_q;
    logic [XLEN-1:0] out_instr_q;
    tu_op_resp_t     out_flags_q;
    logic            accept;
    logic            ret;
    logic            keep;

    // Buffer is always drained by the time data returns
    assign o_req.req  = ~wait_q & ~i_stall & ~i_flush;
    assign o_req.addr = pc_q;

    assign accept = o_req.req & i_resp.addr_ok;
    assign ret    = wait_q & i_resp.data_ok;
    assign keep   = ret & ~i_flush;               // Result from the live path

    assign o_finish = ret | (i_stall & ~wait_q);  // Nothing of ours left on the bus

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            pc_q        <= RESET_PC;
            wait_q      <= 1'b0;
            out_valid_q <= 1'b0;
        end
        else
        begin
            if (accept)
                wait_q <= 1'b1;
            else if (ret)
                wait_q <= 1'b0;

            if (i_flush)
                pc_q <= i_redirect_pc;
            else if (keep)
                pc_q <= pc_q + XLEN'(4);

            if (i_flush)
                out_valid_q <= 1'b0;
            else if (keep)
                out_valid_q <= 1'b1;
            else if (!i_stall)
                out_valid_q <= 1'b0;               // Consumed
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            flags_q <= i_tu;
        if (keep)
        begin
            out_pc_q    <= pc_q;
            out_instr_q <= i_resp.rdata;
            out_flags_q <= flags_q;
        end
    end

    assign o_fetch.valid = out_valid_q;
    assign o_fetch.pc    = out_pc_q;
    assign o_fetch.instr = out_instr_q;
    assign o_fetch.flags = out_flags_q;

endmodule

/* verilog/cacheop_req.sv */
`timescale 1ns/1ps

module cacheop_req import ibus_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_stall,
    input  cop_cmd_t    i_cmd,
    input  cop_kind_t   i_kind,
    input  ibus_resp_t  i_resp,
    input  tu_op_resp_t i_tu,
    output ibus_req_t   o_req,
    output cop_kind_t   o_op,
    output logic        o_done,
    output tu_op_resp_t o_flags
);

    logic            busy_q;
    logic            addr_done_q;
    cop_kind_t       kind_q;
    logic [XLEN-1:0] addr_q;
    tu_op_resp_t     flags_q;
    logic            done_q;
    logic            capture;
    logic            accept;
    logic            ret;

    assign capture = i_cmd.valid & i_stall & ~busy_q & (i_kind != NONE);
    assign accept  = o_req.req & i_resp.addr_ok;
    assign ret     = addr_done_q & i_resp.data_ok;

    assign o_req.req  = busy_q & ~addr_done_q;
    assign o_req.addr = addr_q;

    // Data phase is claimed only once our address is in
    assign o_op = !busy_q ? NONE : (addr_done_q ? ADDR_DATA : ADDR);

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy_q      <= 1'b0;
            addr_done_q <= 1'b0;
            kind_q      <= NONE;
            done_q      <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (capture)
            begin
                busy_q <= 1'b1;
                kind_q <= i_kind;
            end
            else if (accept)
            begin
                if (kind_q == ADDR_DATA)
                    addr_done_q <= 1'b1;
                else
                begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;                // Index op ends at accept
                end
            end
            else if (ret)
            begin
                busy_q      <= 1'b0;
                addr_done_q <= 1'b0;
                done_q      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
            addr_q <= i_cmd.addr;
        if (accept)
            flags_q <= i_tu;
    end

    assign o_done  = done_q;
    assign o_flags = flags_q;

endmodule

/* verilog/inst_req_select.sv */
`timescale 1ns/1ps

module inst_req_select import ibus_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_stall,
    input  logic        i_flush,
    input  cop_kind_t   i_op,
    input  logic        i_finish_f,

    input  ibus_req_t   i_req_f,
    input  ibus_req_t   i_req_c,
    output ibus_req_t   o_req,

    input  ibus_resp_t  i_resp,
    output ibus_resp_t  o_resp_f,
    output ibus_resp_t  o_resp_c,

    input  tu_op_resp_t i_tu,
    output tu_op_resp_t o_tu_f,
    output tu_op_resp_t o_tu_c
);

    logic finish_his_q;
    logic first_cycle_q;
    logic fetch_owns;
    logic cop_owns;

    // History of the current stall window
    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            finish_his_q  <= 1'b0;
            first_cycle_q <= 1'b1;
        end
        else if (i_flush || !i_stall)
        begin
            finish_his_q  <= 1'b0;
            first_cycle_q <= 1'b1;
        end
        else
        begin
            if (finish_his_q)
                first_cycle_q <= 1'b0;
            if (i_finish_f)
                finish_his_q <= 1'b1;
        end
    end

    // Fetch drains first, then one dead cycle, then the cache op
    assign fetch_owns = ~i_op[1] | ~finish_his_q;
    assign cop_owns   = i_op[1] & finish_his_q & ~first_cycle_q;

    always_comb
    begin
        if (fetch_owns)
            o_req = i_req_f;
        else if (cop_owns)
            o_req = i_req_c;
        else
            o_req = '0;                            // Masked cycle
    end

    always_comb
    begin
        o_resp_f = i_resp;
        o_resp_c = i_resp;
        o_resp_f.addr_ok = fetch_owns & i_resp.addr_ok;
        o_resp_c.addr_ok = cop_owns & i_resp.addr_ok;

        if (i_op[0])
            o_resp_f.data_ok = 1'b0;
        else
            o_resp_c.data_ok = 1'b0;
    end

    always_comb
    begin
        o_tu_f = '0;
        o_tu_c = '0;
        if (fetch_owns)
            o_tu_f = i_tu;
        if (cop_owns)
            o_tu_c = i_tu;
    end

endmodule

/* verilog/inst_mem_tu.sv */
`timescale 1ns/1ps

module inst_mem_tu import ibus_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    input  ibus_req_t   i_req,
    output ibus_resp_t  o_resp,
    output tu_op_resp_t o_tu
);

    logic [XLEN-1:0]   rom [ROM_WORDS];
    logic              pending_q;
    logic [XLEN-1:0]   rdata_q;
    logic [ROM_AW-1:0] index;
    logic [3:0]        tag;
    logic              hit;
    logic              hit_valid;

    initial
    begin
        $readmemh(IMEM_FILE, rom);
    end

    assign index = i_req.addr[ROM_AW+1:2];
    assign tag   = i_req.addr[29:26];          // Virtual region

    assign o_resp.addr_ok = i_req.req & ~pending_q;
    assign o_resp.data_ok = pending_q;
    assign o_resp.rdata   = rdata_q;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            pending_q <= 1'b0;
        else
            pending_q <= o_resp.addr_ok;
    end

    always_ff @(posedge clk)
    begin
        if (o_resp.addr_ok)
            rdata_q <= rom[index];
    end

    // First matching entry wins
    always_comb
    begin
        hit       = 1'b0;
        hit_valid = 1'b0;
        for (int i = 0; i < PT_ENTRIES; i++)
        begin
            if (!hit && PAGE_TABLE[i].tag == tag)
            begin
                hit       = 1'b1;
                hit_valid = PAGE_TABLE[i].valid;
            end
        end
    end

    // kuseg and kseg2/3 go through the table
    assign o_tu.mapped      = ~i_req.addr[31] | (i_req.addr[31:30] == 2'b11);
    assign o_tu.tlb_refill  = o_tu.mapped & ~hit;
    assign o_tu.tlb_invalid = o_tu.mapped & hit & ~hit_valid;

endmodule

/* verilog/ifetch_top.sv */
`timescale 1ns/1ps

module ifetch_top import ibus_pkg::*; (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_stall,
    input  logic            i_flush,
    input  logic [XLEN-1:0] i_redirect_pc,
    input  cop_cmd_t        i_cop_cmd,
    input  cop_kind_t       i_cop_kind,
    output fetch_out_t      o_fetch,
    output logic            o_cop_done,
    output tu_op_resp_t     o_cop_flags
);

    ibus_req_t   req_f;
    ibus_req_t   req_c;
    ibus_req_t   req_bus;
    ibus_resp_t  resp_f;
    ibus_resp_t  resp_c;
    ibus_resp_t  resp_bus;
    tu_op_resp_t tu_f;
    tu_op_resp_t tu_c;
    tu_op_resp_t tu_bus;
    logic        finish_f;
    cop_kind_t   cop_op;

    fetch_req u_fetch_req (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_redirect_pc (i_redirect_pc),
        .i_resp        (resp_f),
        .i_tu          (tu_f),
        .o_req         (req_f),
        .o_finish      (finish_f),
        .o_fetch       (o_fetch)
    );

    cacheop_req u_cacheop_req (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_stall (i_stall),
        .i_cmd   (i_cop_cmd),
        .i_kind  (i_cop_kind),
        .i_resp  (resp_c),
        .i_tu    (tu_c),
        .o_req   (req_c),
        .o_op    (cop_op),
        .o_done  (o_cop_done),
        .o_flags (o_cop_flags)
    );

    inst_req_select u_inst_req_select (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_op       (cop_op),
        .i_finish_f (finish_f),
        .i_req_f    (req_f),
        .i_req_c    (req_c),
        .o_req      (req_bus),
        .i_resp     (resp_bus),
        .o_resp_f   (resp_f),
        .o_resp_c   (resp_c),
        .i_tu       (tu_bus),
        .o_tu_f     (tu_f),
        .o_tu_c     (tu_c)
    );

    inst_mem_tu u_inst_mem_tu (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_req   (req_bus),
        .o_resp  (resp_bus),
        .o_tu    (tu_bus)
    );

endmodule

/* dv/ifetch_chk.sv */
`timescale 1ns/1ps

module ifetch_chk import ibus_pkg::*; (
    input logic       clk,
    input logic       i_rst_n,
    input ibus_resp_t o_resp_f,
    input ibus_resp_t o_resp_c,
    input logic       cop_owns
);

    // Fetch data still in flight after its accept
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_resp_f.addr_ok |=> !cop_owns)
        else $error("bus handed to the cache op while fetch data was pending");

    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_resp_c.data_ok |-> $past(o_resp_c.addr_ok))
        else $error("data_ok routed to the cache op without its own accept");

endmodule

bind inst_req_select ifetch_chk u_ifetch_chk (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .o_resp_f (o_resp_f),
    .o_resp_c (o_resp_c),
    .cop_owns (cop_owns)
);

/* dv/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import ibus_pkg::*; (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_stall,
    input  logic            i_flush,
    input  logic [XLEN-1:0] i_redirect_pc,
    input  cop_cmd_t        i_cop_cmd,
    input  cop_kind_t       i_cop_kind,
    input  fetch_out_t      i_fetch,
    input  logic            i_cop_done,
    input  tu_op_resp_t     i_cop_flags,
    output int              o_errors,
    output int              o_results,
    output int              o_cops,
    output logic            o_cop_busy
);

    logic [31:0] rom [32];
    logic [31:0] exp_pc;
    logic [31:0] cop_addr;
    logic        prev_valid;
    logic        prev_stall;
    logic        prev_flush;
    fetch_out_t  prev_fetch;

    initial
    begin
        $readmemh("imem.hex", rom);
        o_errors   = 0;
        o_results  = 0;
        o_cops     = 0;
        o_cop_busy = 1'b0;
    end

    // kuseg and kseg2/3 mapped, first table hit decides
    function automatic tu_op_resp_t expect_flags(input logic [31:0] a);
        tu_op_resp_t f;
        logic        found;
        f = '0;
        found = 1'b0;
        f.mapped = !a[31] || (a[31:30] == 2'b11);
        for (int i = 0; i < 4; i++)
        begin
            if (!found && PAGE_TABLE[i].tag == a[29:26])
            begin
                found = 1'b1;
                f.tlb_invalid = f.mapped && !PAGE_TABLE[i].valid;
            end
        end
        f.tlb_refill = f.mapped && !found;
        return f;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            o_errors++;
            $display("[FAIL] %s expected=%h actual=%h", name, exp, act);
        end
    endtask

    always @(negedge clk)
    begin
        if (!i_rst_n)
        begin
            exp_pc     = RESET_PC;
            prev_valid = 1'b0;
            prev_stall = 1'b0;
            prev_flush = 1'b0;
            o_cop_busy = 1'b0;
        end
        else
        begin
            if (prev_valid && prev_stall && !prev_flush)
            begin                                          // Held buffer
                check_val("hold_valid", 32'(prev_fetch.valid), 32'(i_fetch.valid));
                check_val("hold_pc", prev_fetch.pc, i_fetch.pc);
                check_val("hold_instr", prev_fetch.instr, i_fetch.instr);
                check_val("hold_flags", 32'(prev_fetch.flags), 32'(i_fetch.flags));
            end
            else if (i_fetch.valid)
            begin
                check_val("fetch_pc", exp_pc, i_fetch.pc);
                check_val("fetch_instr", rom[exp_pc[6:2]], i_fetch.instr);
                check_val("fetch_flags", 32'(expect_flags(exp_pc)), 32'(i_fetch.flags));
                exp_pc = exp_pc + 32'd4;
                o_results++;
            end
            if (i_flush)
                exp_pc = i_redirect_pc;

            if (i_cop_done)
            begin
                if (!o_cop_busy)
                begin
                    o_errors++;
                    $display("o_cop_done pulsed with no cache op outstanding");
                end
                else
                    check_val("cop_flags", 32'(expect_flags(cop_addr)), 32'(i_cop_flags));
                o_cop_busy = 1'b0;
                o_cops++;
            end
            if (i_cop_cmd.valid && i_stall && i_cop_kind != NONE && !o_cop_busy)
            begin
                o_cop_busy = 1'b1;
                cop_addr   = i_cop_cmd.addr;
            end

            prev_valid = i_fetch.valid;
            prev_stall = i_stall;
            prev_flush = i_flush;
            prev_fetch = i_fetch;
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top import ibus_pkg::*; ();

    logic            clk;
    logic            i_rst_n;
    logic            i_stall;
    logic            i_flush;
    logic [XLEN-1:0] i_redirect_pc;
    cop_cmd_t        i_cop_cmd;
    cop_kind_t       i_cop_kind;
    fetch_out_t      o_fetch;
    logic            o_cop_done;
    tu_op_resp_t     o_cop_flags;
    int              errors;
    int              results;
    int              cops;
    logic            cop_busy;
    int              timeouts;
    logic            timed_out;

    ifetch_top u_ifetch_top (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_redirect_pc (i_redirect_pc),
        .i_cop_cmd     (i_cop_cmd),
        .i_cop_kind    (i_cop_kind),
        .o_fetch       (o_fetch),
        .o_cop_done    (o_cop_done),
        .o_cop_flags   (o_cop_flags)
    );

    tb_checker u_checker (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_redirect_pc (i_redirect_pc),
        .i_cop_cmd     (i_cop_cmd),
        .i_cop_kind    (i_cop_kind),
        .i_fetch       (o_fetch),
        .i_cop_done    (o_cop_done),
        .i_cop_flags   (o_cop_flags),
        .o_errors      (errors),
        .o_results     (results),
        .o_cops        (cops),
        .o_cop_busy    (cop_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Half the targets land on a page table tag
    function automatic logic [31:0] random_addr(input logic [31:0] r, input logic [31:0] sel);
        logic [3:0] tag;
        tag = sel[0] ? PAGE_TABLE[sel[2:1]].tag : r[29:26];
        return {r[31:30], tag, r[25:2], 2'b00};
    endfunction

    initial
    begin
        logic [31:0] r;
        logic [31:0] s;
        int          n;
        int          step;
        logic        got;
        void'($urandom(32'h46ab_c452));
        i_rst_n       = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_redirect_pc = '0;
        i_cop_cmd     = '0;
        i_cop_kind    = NONE;
        timeouts      = 0;
        timed_out     = 1'b0;
        repeat (8) @(posedge clk);
        i_rst_n <= 1'b1;
        for (int it = 0; it < 400 && !timed_out; it++)
        begin
            step = $urandom_range(0, 9);
            r = $urandom();
            s = $urandom();
            if (step <= 4)
                repeat ($urandom_range(1, 6)) @(posedge clk);
            else if (step == 5)
            begin
                @(posedge clk);
                i_flush       <= 1'b1;
                i_redirect_pc <= random_addr(r, s);
                @(posedge clk);
                i_flush <= 1'b0;
            end
            else if (step <= 7)
            begin
                @(posedge clk);
                i_stall <= 1'b1;
                repeat ($urandom_range(1, 5)) @(posedge clk);
                i_stall <= 1'b0;
            end
            else
            begin
                @(posedge clk);
                i_stall <= 1'b1;
                n = $urandom_range(1, 3);
                repeat (n) @(posedge clk);
                i_cop_cmd  <= '{valid: 1'b1, addr: random_addr(r, s)};
                i_cop_kind <= s[3] ? ADDR : ADDR_DATA;
                @(posedge clk);
                i_cop_cmd  <= '0;
                i_cop_kind <= NONE;
                got = 1'b0;
                for (int cnt = 0; cnt < 64 && !got; cnt++)
                begin
                    @(negedge clk);
                    got = o_cop_done;
                end
                if (!got)
                begin
                    $display("Timeout: o_cop_done did not arrive within 64 cycles");
                    timeouts++;
                    timed_out = 1'b1;
                end
                @(posedge clk);
                i_stall <= 1'b0;
            end
        end
        repeat (6) @(posedge clk);
        if (results < 20)
        begin
            $display("Too few fetch results were seen: %0d", results);
            timeouts++;
        end
        if (cop_busy)
        begin
            $display("A cache op was still outstanding at the end of the run");
            timeouts++;
        end
        $display("errors: checks=%0d other=%0d (fetches=%0d cache_ops=%0d)",
                 errors, timeouts, results, cops);
        if (errors == 0 && timeouts == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* imem.hex */
// One 32-bit instruction word per line, ROM index 0 to 31
3c1dbfc0
27bd1000
3c08a000
35080040
8d090000
25290001
ad090004
1120fffd
00000000
3c0a0000
254a0010
01495021
0c000014
00000000
240b0005
016b5823
15600002
00000000
bc000000
bc080004
03e00008
00000000
24020001
00431025
30420fff
00021080
1000ffff
00000000
42000018
8fbf0014
27bd0018
03e00008

/* vlog.f */
verilog/ibus_pkg.sv
verilog/fetch_req.sv
verilog/cacheop_req.sv
verilog/inst_req_select.sv
verilog/inst_mem_tu.sv
verilog/ifetch_top.sv
dv/ifetch_chk.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)
